/* src/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Datapath widths
`define ADDR_WIDTH 32
`define INSTR_WIDTH 32

// A cache line and a memory block are the same size, sixteen 32-bit words
`define BLOCK_WIDTH 512
`define WORDS_PER_BLOCK 16
`define WORD_SEL_BITS 4
`define BLOCK_OFFSET_BITS 6

// Direct-mapped instruction cache geometry
`define ICACHE_LINES 16
`define INDEX_BITS 4
`define TAG_WIDTH 22

// Backing memory holds 64 blocks, 4 KB in total
`define MEM_BLOCKS 64
`define MEM_BLOCK_BITS 6
`define MEM_LATENCY 4
`define LAT_CNT_WIDTH 3

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* src/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

    // Byte address into the program space
    typedef logic [`ADDR_WIDTH-1:0] addrT;

    // One instruction word
    typedef logic [`INSTR_WIDTH-1:0] instrT;

    // A full cache line or memory block
    typedef logic [`BLOCK_WIDTH-1:0] blockT;

    // Address bits 31 to 10, compared against the stored tag
    typedef logic [`TAG_WIDTH-1:0] tagT;

    // Address bits 9 to 6, which select the cache line
    typedef logic [`INDEX_BITS-1:0] lineIdxT;

    // Address bits 5 to 2, which select a word inside a block
    typedef logic [`WORD_SEL_BITS-1:0] wordSelT;

    // Address bits 11 to 6, which select a block in the backing memory
    typedef logic [`MEM_BLOCK_BITS-1:0] memBlkIdxT;

    // States of the miss handling FSM
    typedef enum logic [1:0] {Idle, Request, Fill} refillStateT;

endpackage

/* src/programCounter.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module programCounter (
    input  logic            clk,
    input  logic            rst,
    // Freezes the PC while the core is stopped
    input  logic            halt,
    // Combined hold request from decode, memory stage and the cache
    input  logic            stallPC,
    // Address to fetch next, either PC plus 4 or a branch target
    input  fetch_pkg::addrT nextAddr,
    output fetch_pkg::addrT currAddr
);

    // Any hold condition keeps the current address
    logic advance;

    assign advance = ~halt & ~stallPC;

    // The PC only moves when nothing holds it, so a stalled instruction repeats
    always_ff @(posedge clk) begin
        if (rst) begin
            currAddr <= `RESET_PC;
        end else if (advance) begin
            currAddr <= nextAddr;
        end
    end

endmodule

/* src/instrCache.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module instrCache (
    input  logic             clk,
    input  logic             rst,
    // Fetch address, looked up combinationally
    input  fetch_pkg::addrT  addr,
    // Line write strobe from the refill controller
    input  logic             fillEn,
    // Block-aligned address of the line being written
    input  fetch_pkg::addrT  fillAddr,
    // Block returned by the backing memory
    input  fetch_pkg::blockT blkIn,
    output fetch_pkg::instrT instrOut,
    output logic             hit,
    output logic             miss
);

    // Per-line storage
    logic [`ICACHE_LINES-1:0] validBits;
    fetch_pkg::tagT           tagArr [`ICACHE_LINES];
    fetch_pkg::blockT         dataArr [`ICACHE_LINES];

    // Fields of the fetch address
    fetch_pkg::tagT           lookupTag;
    fetch_pkg::lineIdxT       lookupIdx;
    fetch_pkg::wordSelT       lookupWord;

    // Fields of the fill address
    fetch_pkg::tagT           fillTag;
    fetch_pkg::lineIdxT       fillIdx;

    // Selected line, before the word multiplexer
    fetch_pkg::blockT         lineData;

    // The byte offset inside a word is ignored, fetches are word aligned
    assign lookupTag  = addr[`ADDR_WIDTH-1 -: `TAG_WIDTH];
    assign lookupIdx  = addr[`BLOCK_OFFSET_BITS +: `INDEX_BITS];
    assign lookupWord = addr[2 +: `WORD_SEL_BITS];

    assign fillTag = fillAddr[`ADDR_WIDTH-1 -: `TAG_WIDTH];
    assign fillIdx = fillAddr[`BLOCK_OFFSET_BITS +: `INDEX_BITS];

    // A line hits only when it holds valid data for the same tag
    assign hit  = validBits[lookupIdx] && (tagArr[lookupIdx] == lookupTag);
    assign miss = ~hit;

    // Word select within the addressed line
    assign lineData = dataArr[lookupIdx];
    assign instrOut = lineData[lookupWord*`INSTR_WIDTH +: `INSTR_WIDTH];

    // Valid bits start cleared, so every line misses once after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
        end else if (fillEn) begin
            validBits[fillIdx] <= 1'b1;
        end
    end

    // The whole line and its tag are replaced at once on a fill
    always_ff @(posedge clk) begin
        if (fillEn) begin
            dataArr[fillIdx] <= blkIn;
            tagArr[fillIdx]  <= fillTag;
        end
    end

    // A conflicting line is simply overwritten, there is no write-back
    // since instruction memory is read only from this side

endmodule

/* src/refillController.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module refillController (
    input  logic            clk,
    input  logic            rst,
    // Miss for the current fetch address, already qualified by halt
    input  logic            miss,
    input  fetch_pkg::addrT missAddr,
    // One-cycle strobe from memory with the requested block
    input  logic            memDataValid,
    output logic            memRequest,
    output fetch_pkg::addrT memBlockAddr,
    output logic            fillEn,
    output fetch_pkg::addrT fillAddr,
    output logic            busy
);

    fetch_pkg::refillStateT state;
    fetch_pkg::refillStateT nextState;

    // Address of the outstanding block, low offset bits cleared
    fetch_pkg::addrT        blockAddr;

    // High for the first cycle spent in Request
    logic                   reqPulse;

    // Starting a refill happens only from Idle
    logic                   startRefill;

    assign startRefill = (state == fetch_pkg::Idle) && miss;

    always_comb begin
        nextState = state;
        case (state)
            fetch_pkg::Idle: begin
                if (miss) begin
                    nextState = fetch_pkg::Request;
                end
            end
            // Wait here until memory returns the block
            fetch_pkg::Request: begin
                if (memDataValid) begin
                    nextState = fetch_pkg::Fill;
                end
            end
            // The line was written on entry, one cycle later the lookup hits
            fetch_pkg::Fill: begin
                nextState = fetch_pkg::Idle;
            end
            default: begin
                nextState = fetch_pkg::Idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fetch_pkg::Idle;
            reqPulse <= 1'b0;
        end else begin
            state    <= nextState;
            reqPulse <= startRefill;
        end
    end

    // The miss address is captured once so a moving nextPC cannot change it
    always_ff @(posedge clk) begin
        if (startRefill) begin
            blockAddr <= {missAddr[`ADDR_WIDTH-1:`BLOCK_OFFSET_BITS],
                          {`BLOCK_OFFSET_BITS{1'b0}}};
        end
    end

    assign memRequest   = reqPulse;
    assign memBlockAddr = blockAddr;
    assign fillAddr     = blockAddr;

    // Data is only accepted while a request is outstanding
    assign fillEn = (state == fetch_pkg::Request) && memDataValid;
    assign busy   = (state != fetch_pkg::Idle);

endmodule

/* src/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             halt,
    // Hold from the memory stage while a DMA transfer is in progress
    input  logic             stallDMAMem,
    // Hold from decode when the instruction cannot be accepted yet
    input  logic             blockInstruction,
    input  fetch_pkg::addrT  nextPC,
    // Refill data returned by the backing memory
    input  logic             memDataValid,
    input  fetch_pkg::blockT memBlockData,
    output fetch_pkg::instrT instr,
    output fetch_pkg::addrT  pcPlus4,
    output fetch_pkg::addrT  currPC,
    output logic             instrValid,
    output logic             memRequest,
    output fetch_pkg::addrT  memBlockAddr
);

    logic            cacheHit;
    logic            cacheMiss;
    logic            refillMiss;
    logic            fillEn;
    logic            busy;
    logic            stallPC;
    fetch_pkg::addrT fillAddr;

    // Any hold source, or a refill in progress, freezes the PC
    assign stallPC = stallDMAMem | blockInstruction | cacheMiss | busy;

    // No refill is started while halted, memory may still be loading then
    assign refillMiss = cacheMiss & ~halt;

    // A held PC still presents its instruction, decode decides whether to take it
    assign instrValid = cacheHit & ~busy & ~halt;

    // Sequential successor of the current fetch address
    assign pcPlus4 = currPC + fetch_pkg::addrT'(4);

    programCounter programCounter_i (
        .clk      (clk),
        .rst      (rst),
        .halt     (halt),
        .stallPC  (stallPC),
        .nextAddr (nextPC),
        .currAddr (currPC)
    );

    instrCache instrCache_i (
        .clk      (clk),
        .rst      (rst),
        .addr     (currPC),
        .fillEn   (fillEn),
        .fillAddr (fillAddr),
        .blkIn    (memBlockData),
        .instrOut (instr),
        .hit      (cacheHit),
        .miss     (cacheMiss)
    );

    refillController refillController_i (
        .clk          (clk),
        .rst          (rst),
        .miss         (refillMiss),
        .missAddr     (currPC),
        .memDataValid (memDataValid),
        .memRequest   (memRequest),
        .memBlockAddr (memBlockAddr),
        .fillEn       (fillEn),
        .fillAddr     (fillAddr),
        .busy         (busy)
    );

endmodule

/* src/blockMemory.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module blockMemory (
    input  logic             clk,
    input  logic             rst,
    // Word write port used to place the program before fetching starts
    input  logic             loadEn,
    input  fetch_pkg::addrT  loadAddr,
    input  fetch_pkg::instrT loadData,
    // Block read request from the fetch refill controller
    input  logic             memRequest,
    input  fetch_pkg::addrT  memBlockAddr,
    output logic             memDataValid,
    output fetch_pkg::blockT memBlockData
);

    fetch_pkg::blockT             memArr [`MEM_BLOCKS];

    // Position of the word being loaded
    fetch_pkg::memBlkIdxT         loadBlk;
    fetch_pkg::wordSelT           loadWord;

    // Block held for the outstanding request
    fetch_pkg::memBlkIdxT         reqBlk;

    // Cycles left until the block is presented, zero when idle
    logic [`LAT_CNT_WIDTH-1:0]    latCnt;

    // Address bits above the 4 KB space are ignored here
    assign loadBlk  = loadAddr[`BLOCK_OFFSET_BITS +: `MEM_BLOCK_BITS];
    assign loadWord = loadAddr[2 +: `WORD_SEL_BITS];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            memArr[loadBlk][loadWord*`INSTR_WIDTH +: `INSTR_WIDTH] <= loadData;
        end
    end

    always_ff @(posedge clk) begin
        if (memRequest) begin
            reqBlk <= memBlockAddr[`BLOCK_OFFSET_BITS +: `MEM_BLOCK_BITS];
        end
    end

    // Counter loaded on the request cycle, the block appears when it reaches one
    always_ff @(posedge clk) begin
        if (rst) begin
            latCnt <= '0;
        end else if (memRequest) begin
            latCnt <= `LAT_CNT_WIDTH'(`MEM_LATENCY);
        end else if (latCnt != '0) begin
            latCnt <= latCnt - 1'b1;
        end
    end

    // Valid exactly MEM_LATENCY cycles after the request
    assign memDataValid = (latCnt == `LAT_CNT_WIDTH'(1));
    assign memBlockData = memArr[reqBlk];

endmodule

/* src/fetchTop.sv */
`timescale 1ns/1ps

module fetchTop (
    input  logic             clk,
    input  logic             rst,
    input  logic             halt,
    input  logic             stallDMAMem,
    input  logic             blockInstruction,
    input  fetch_pkg::addrT  nextPC,
    // Program load port into the backing memory
    input  logic             loadEn,
    input  fetch_pkg::addrT  loadAddr,
    input  fetch_pkg::instrT loadData,
    output fetch_pkg::instrT instr,
    output fetch_pkg::addrT  pcPlus4,
    output fetch_pkg::addrT  currPC,
    output logic             instrValid
);

    // Block refill path between the fetch stage and memory
    logic             memRequest;
    logic             memDataValid;
    fetch_pkg::addrT  memBlockAddr;
    fetch_pkg::blockT memBlockData;

    fetchStage fetchStage_i (
        .clk              (clk),
        .rst              (rst),
        .halt             (halt),
        .stallDMAMem      (stallDMAMem),
        .blockInstruction (blockInstruction),
        .nextPC           (nextPC),
        .memDataValid     (memDataValid),
        .memBlockData     (memBlockData),
        .instr            (instr),
        .pcPlus4          (pcPlus4),
        .currPC           (currPC),
        .instrValid       (instrValid),
        .memRequest       (memRequest),
        .memBlockAddr     (memBlockAddr)
    );

    blockMemory blockMemory_i (
        .clk          (clk),
        .rst          (rst),
        .loadEn       (loadEn),
        .loadAddr     (loadAddr),
        .loadData     (loadData),
        .memRequest   (memRequest),
        .memBlockAddr (memBlockAddr),
        .memDataValid (memDataValid),
        .memBlockData (memBlockData)
    );

endmodule

/* dv/fetchTb.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetchTb;

    localparam int RST_CYCLES    = 5;
    localparam int MEM_WORDS     = `MEM_BLOCKS * `WORDS_PER_BLOCK;
    // Three full blocks and a few words into the fourth
    localparam int SEQ_FETCHES   = 3 * `WORDS_PER_BLOCK + 4;
    localparam int REVISIT_COUNT = `WORDS_PER_BLOCK;
    localparam int CONFLICT_COUNT = 6;
    localparam int JUMPS         = 40;
    localparam int JUMP_RUN      = 2;
    localparam int STRESS_CYCLES = 1500;
    // Longest gap of invalid cycles that one refill may cause
    localparam int WAIT_LIMIT    = `MEM_LATENCY + 8;
    localparam int CYCLE_LIMIT   = RST_CYCLES + MEM_WORDS + STRESS_CYCLES + 100 +
        (SEQ_FETCHES + REVISIT_COUNT + CONFLICT_COUNT + JUMPS * JUMP_RUN + 1) * WAIT_LIMIT;

    // Three addresses that all map to line 5 with tags 0, 1 and 2
    localparam fetch_pkg::addrT CONFLICT_A = 32'h0000_0140;
    localparam fetch_pkg::addrT CONFLICT_B = 32'h0000_0540;
    localparam fetch_pkg::addrT CONFLICT_C = 32'h0000_0940;

    logic             clk;
    logic             rst;
    logic             halt;
    logic             stallDMAMem;
    logic             blockInstruction;
    fetch_pkg::addrT  nextPC;
    logic             loadEn;
    fetch_pkg::addrT  loadAddr;
    fetch_pkg::instrT loadData;
    fetch_pkg::instrT instr;
    fetch_pkg::addrT  pcPlus4;
    fetch_pkg::addrT  currPC;
    logic             instrValid;

    // Copy of everything written through the load port
    fetch_pkg::instrT shadowMem [MEM_WORDS];

    fetch_pkg::addrT  predictedPC;
    bit               pcKnown;
    int               checkedCount;
    int               cycleCount;
    int               invalidRun;

    fetchTop fetchTop_i (
        .clk              (clk),
        .rst              (rst),
        .halt             (halt),
        .stallDMAMem      (stallDMAMem),
        .blockInstruction (blockInstruction),
        .nextPC           (nextPC),
        .loadEn           (loadEn),
        .loadAddr         (loadAddr),
        .loadData         (loadData),
        .instr            (instr),
        .pcPlus4          (pcPlus4),
        .currPC           (currPC),
        .instrValid       (instrValid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Expected instruction word, taken from the program as it was loaded
    function automatic fetch_pkg::instrT expectedInstr(input fetch_pkg::addrT addr);
        return shadowMem[addr[`MEM_BLOCK_BITS+`BLOCK_OFFSET_BITS-1:2]];
    endfunction

    // Fill the whole memory with random words while halt keeps fetch idle
    task automatic loadProgram();
        for (int i = 0; i < MEM_WORDS; i++) begin
            loadEn       = 1'b1;
            loadAddr     = fetch_pkg::addrT'(i * 4);
            loadData     = $urandom;
            shadowMem[i] = loadData;
            @(negedge clk);
        end
        loadEn = 1'b0;
    endtask

    // Called on a falling edge, accepts the current instruction and steers the PC to target
    task automatic acceptFetch(input fetch_pkg::addrT target, input bit mustHit,
                               input bit mustMiss);
        int waited;
        waited = 0;
        if (mustHit) begin
            assert (instrValid) else
                abortRun($sformatf("[FAIL] instrValid at currPC %h: expected 1, got 0",
                                   currPC));
        end
        if (mustMiss) begin
            assert (!instrValid) else
                abortRun($sformatf("[FAIL] instrValid at currPC %h: expected 0, got 1",
                                   currPC));
        end
        nextPC           = target;
        blockInstruction = 1'b0;
        stallDMAMem      = 1'b0;
        while (!instrValid) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abortRun($sformatf("Instruction at %h never became valid", currPC));
            end
        end
        // The rising edge in between takes the instruction and loads target
        @(negedge clk);
    endtask

    // Compares every valid instruction and predicts where the PC goes next
    always @(posedge clk) begin
        if (rst) begin
            pcKnown = 1'b0;
        end else begin
            if (pcKnown) begin
                assert (currPC == predictedPC) else
                    abortRun($sformatf("[FAIL] currPC: expected %h, got %h",
                                       predictedPC, currPC));
            end
            if (halt) begin
                assert (!instrValid) else
                    abortRun("[FAIL] instrValid while halted: expected 0, got 1");
            end
            if (instrValid) begin
                assert (instr == expectedInstr(currPC)) else
                    abortRun($sformatf("[FAIL] instr at %h: expected %h, got %h",
                                       currPC, expectedInstr(currPC), instr));
                assert (pcPlus4 == currPC + 32'd4) else
                    abortRun($sformatf("[FAIL] pcPlus4 at %h: expected %h, got %h",
                                       currPC, currPC + 32'd4, pcPlus4));
                checkedCount++;
            end
            // A valid instruction with no hold moves the PC, anything else keeps it
            if (instrValid && !blockInstruction && !stallDMAMem) begin
                predictedPC = nextPC;
            end else begin
                predictedPC = currPC;
            end
            pcKnown = 1'b1;
        end
    end

    // Refill watchdog and overall cycle limit
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            abortRun("Timeout, the run exceeded its cycle limit");
        end
        if (rst || instrValid) begin
            invalidRun = 0;
        end else if (!halt) begin
            invalidRun++;
            if (invalidRun > WAIT_LIMIT) begin
                abortRun($sformatf("No valid instruction for too long at %h", currPC));
            end
        end
    end

    initial begin
        rst              = 1'b1;
        halt             = 1'b1;
        stallDMAMem      = 1'b0;
        blockInstruction = 1'b0;
        nextPC           = '0;
        loadEn           = 1'b0;
        loadAddr         = '0;
        loadData         = '0;
        checkedCount     = 0;
        cycleCount       = 0;
        invalidRun       = 0;
        pcKnown          = 1'b0;
        predictedPC      = '0;
        void'($urandom(32'h6d1b_e9ea));

        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        assert (currPC == `RESET_PC) else
            abortRun($sformatf("[FAIL] currPC after reset: expected %h, got %h",
                               `RESET_PC, currPC));
        assert (!instrValid) else
            abortRun("[FAIL] instrValid after reset: expected 0, got 1");

        loadProgram();
        halt = 1'b0;

        // All valid bits are clear, so the first fetch is still refilling here
        @(negedge clk);
        assert (!instrValid) else
            abortRun("[FAIL] instrValid on first fetch: expected 0, got 1");

        // Word 0 of each block misses and the rest of the block hits
        for (int i = 0; i < SEQ_FETCHES; i++) begin
            acceptFetch(pcPlus4, currPC[5:2] != 4'd0, currPC[5:2] == 4'd0);
        end

        // Back to block 0, which is still cached, and through it without a refill
        acceptFetch(32'h0, 1'b1, 1'b0);
        for (int i = 0; i < REVISIT_COUNT; i++) begin
            acceptFetch(pcPlus4, 1'b1, 1'b0);
        end

        // Every step lands on line 5 with another tag and must refill it
        acceptFetch(CONFLICT_A, 1'b1, 1'b0);
        acceptFetch(CONFLICT_B, 1'b0, 1'b1);
        acceptFetch(CONFLICT_A, 1'b0, 1'b1);
        acceptFetch(CONFLICT_C, 1'b0, 1'b1);
        acceptFetch(CONFLICT_A + 32'd4, 1'b0, 1'b1);
        acceptFetch(pcPlus4, 1'b0, 1'b1);

        for (int j = 0; j < JUMPS; j++) begin
            acceptFetch(fetch_pkg::addrT'($urandom_range(MEM_WORDS - 1, 0) * 4), 1'b0, 1'b0);
            for (int k = 1; k < JUMP_RUN; k++) begin
                acceptFetch(pcPlus4, 1'b0, 1'b0);
            end
        end

        // Random holds and jumps, which also land inside refills
        for (int c = 0; c < STRESS_CYCLES; c++) begin
            blockInstruction = ($urandom_range(3, 0) == 0);
            stallDMAMem      = ($urandom_range(3, 0) == 0);
            halt             = ($urandom_range(9, 0) == 0);
            if ($urandom_range(7, 0) == 0) begin
                nextPC = fetch_pkg::addrT'($urandom_range(MEM_WORDS - 1, 0) * 4);
            end else begin
                nextPC = pcPlus4;
            end
            @(negedge clk);
        end
        halt = 1'b0;
        acceptFetch(pcPlus4, 1'b0, 1'b0);

        if (checkedCount > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abortRun("No valid instruction was ever checked");
        end
    end

endmodule

/* project.f */
+incdir+src
src/fetch_pkg.sv
src/programCounter.sv
src/instrCache.sv
src/refillController.sv
src/fetchStage.sv
src/blockMemory.sv
src/fetchTop.sv
dv/fetchTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fetchTb -f project.f -o fetchSim

simOut=$(./obj_dir/fetchSim 2>&1) || { echo "$simOut"; exit 1; }
echo "$simOut"

if echo "$simOut" | grep -q "ALL CHECKS PASSED"; then
    exit 0
else
    exit 1
fi
